/* source/synth_params.svh */
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

`default_nettype none

// ----------------------------------------
// Clocking and serial rate
// ----------------------------------------
`define SYNTH_CLK_FREQ    1_000_000   // Simulation clock
`define SYNTH_BAUD        31250       // MIDI rate, 32 clocks per bit

// ----------------------------------------
// Sample pacing and waits
// ----------------------------------------
`define SYNTH_SAMPLE_DIV  40          // Clocks between sample requests
`define SYNTH_TIMEOUT     200_000     // Upper bound on any wait, in clocks

`default_nettype wire

`endif

/* source/synth_pkg.sv */
`default_nettype none

package synth_pkg;

    // MIDI command nibble, only the two voice messages are kept apart
    typedef enum logic [3:0] {
        CMD_NOTE_OFF = 4'h8,
        CMD_NOTE_ON  = 4'h9,
        CMD_OTHER    = 4'hF
    } midi_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE,    // No running status
        ST_DATA0,   // Waiting for note
        ST_DATA1    // Waiting for velocity
    } parse_state_e;

    typedef struct packed {
        midi_cmd_e  cmd;
        logic [3:0] channel;
        logic [6:0] data0;    // Note
        logic [6:0] data1;    // Velocity
    } midi_msg_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } stereo_sample_t;

    // Half period in samples, semitone entry shifted down by octave
    function automatic logic [15:0] note_half_period(input logic [6:0] note);
        logic [3:0]  semi;
        logic [3:0]  oct;
        logic [15:0] base;
        semi = 4'(note % 7'd12);
        oct  = 4'(note / 7'd12);
        case (semi)
            4'd0:    base = 16'd3822;
            4'd1:    base = 16'd3608;
            4'd2:    base = 16'd3405;
            4'd3:    base = 16'd3214;
            4'd4:    base = 16'd3034;
            4'd5:    base = 16'd2863;
            4'd6:    base = 16'd2703;
            4'd7:    base = 16'd2551;
            4'd8:    base = 16'd2408;
            4'd9:    base = 16'd2273;
            4'd10:   base = 16'd2145;
            default: base = 16'd2025;
        endcase
        return base >> oct;
    endfunction

endpackage

`default_nettype wire

/* source/uart_rx.sv */
`include "synth_params.svh"
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    localparam int CLKS_PER_BIT = `SYNTH_CLK_FREQ / `SYNTH_BAUD;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int CW           = $clog2(CLKS_PER_BIT);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_WAIT     // Rest of the stop bit before the pulse
    } rx_state_e;

    rx_state_e   state;
    logic [1:0]  rx_sync;
    logic        rx_s;
    logic [CW-1:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;
    logic        bit_end;
    logic        half_end;
    logic        shift_en;

    assign rx_s     = rx_sync[1];
    assign bit_end  = (cnt == CW'(CLKS_PER_BIT - 1));
    assign half_end = (cnt == CW'(HALF_BIT - 1));
    assign shift_en = (state == RX_DATA) && bit_end;

    // ----------------------------------------
    // Input synchronizer, line idles high
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    // ----------------------------------------
    // Bit timing FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            cnt        <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;   // Glitch check
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= rx_s ? RX_WAIT : RX_IDLE;    // Framing error drops byte
                    end
                end
                RX_WAIT: begin
                    if (half_end) begin
                        byte_valid <= 1'b1;
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {rx_s, shreg[7:1]};
        end
    end

    assign byte_data = shreg;

endmodule

`default_nettype wire

/* source/midi_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module midi_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 byte_valid,
    input  logic [7:0]           byte_data,
    output logic                 msg_valid,
    output synth_pkg::midi_msg_t msg
);

    synth_pkg::parse_state_e state;
    synth_pkg::midi_cmd_e    status_cmd;
    synth_pkg::midi_cmd_e    byte_cmd;
    logic [3:0]              status_ch;
    logic [6:0]              data0;

    logic is_realtime;
    logic is_status;
    logic is_system;

    assign is_realtime = (byte_data >= 8'hF8);
    assign is_status   = byte_data[7];
    assign is_system   = (byte_data[7:4] == 4'hF);

    // Command from the upper nibble
    always_comb begin
        case (byte_data[6:4])
            3'h0:    byte_cmd = synth_pkg::CMD_NOTE_OFF;
            3'h1:    byte_cmd = synth_pkg::CMD_NOTE_ON;
            default: byte_cmd = synth_pkg::CMD_OTHER;
        endcase
    end

    // ----------------------------------------
    // Parser state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= synth_pkg::ST_IDLE;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (byte_valid && !is_realtime) begin
                if (is_status) begin
                    // System common clears running status
                    state <= is_system ? synth_pkg::ST_IDLE : synth_pkg::ST_DATA0;
                end else begin
                    case (state)
                        synth_pkg::ST_DATA0: state <= synth_pkg::ST_DATA1;
                        synth_pkg::ST_DATA1: begin
                            state     <= synth_pkg::ST_DATA0;   // Running status
                            msg_valid <= 1'b1;
                        end
                        default: state <= synth_pkg::ST_IDLE;   // Stray data byte
                    endcase
                end
            end
        end
    end

    // ----------------------------------------
    // Stored status and message fields
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (byte_valid && !is_realtime) begin
            if (is_status && !is_system) begin
                status_cmd <= byte_cmd;
                status_ch  <= byte_data[3:0];
            end
            if (!is_status && state == synth_pkg::ST_DATA0) begin
                data0 <= byte_data[6:0];
            end
            if (!is_status && state == synth_pkg::ST_DATA1) begin
                msg.cmd     <= status_cmd;
                msg.channel <= status_ch;
                msg.data0   <= data0;
                msg.data1   <= byte_data[6:0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/pulse_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module pulse_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      msg_valid,
    input  synth_pkg::midi_msg_t      msg,
    input  logic                      sample_req,
    output logic                      sample_rdy,
    output synth_pkg::stereo_sample_t sample
);

    logic               active;
    logic               phase;        // High half of the square
    logic [15:0]        cnt;
    logic [15:0]        half;
    logic [6:0]         note;
    logic signed [15:0] amplitude;
    logic signed [15:0] level;

    logic note_on;
    logic note_off;
    logic half_end;

    // Velocity 0 on a note-on counts as note-off
    assign note_on  = msg_valid && (msg.cmd == synth_pkg::CMD_NOTE_ON) && (msg.data1 != 7'd0);
    assign note_off = msg_valid && (msg.data0 == note) &&
                      ((msg.cmd == synth_pkg::CMD_NOTE_OFF) ||
                       (msg.cmd == synth_pkg::CMD_NOTE_ON && msg.data1 == 7'd0));
    assign half_end = (cnt == half - 16'd1);

    always_comb begin
        if (!active) begin
            level = '0;
        end else if (phase) begin
            level = amplitude;
        end else begin
            level = -amplitude;
        end
    end

    // ----------------------------------------
    // Voice control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active     <= 1'b0;
            phase      <= 1'b1;
            cnt        <= '0;
            sample_rdy <= 1'b0;
        end else begin
            sample_rdy <= sample_req;
            if (sample_req && active) begin
                if (half_end) begin
                    cnt   <= '0;
                    phase <= ~phase;
                end else begin
                    cnt <= cnt + 16'd1;
                end
            end
            // A message overrides the step taken in the same cycle
            if (note_on) begin
                active <= 1'b1;
                phase  <= 1'b1;
                cnt    <= '0;
            end else if (note_off) begin
                active <= 1'b0;
            end
        end
    end

    // Pitch and level of the current note
    always_ff @(posedge clk) begin
        if (note_on) begin
            note      <= msg.data0;
            half      <= synth_pkg::note_half_period(msg.data0);
            amplitude <= {1'b0, msg.data1, 8'h00};   // velocity x 256
        end
    end

    always_ff @(posedge clk) begin
        if (sample_req) begin
            sample.left  <= level;
            sample.right <= level;    // Mono on both channels
        end
    end

endmodule

`default_nettype wire

/* source/sample_out.sv */
`include "synth_params.svh"
`timescale 1ns/100ps
`default_nettype none

module sample_out (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      out_ready,
    input  logic                      sample_rdy,
    input  synth_pkg::stereo_sample_t sample,
    output logic                      sample_req,
    output logic                      out_valid,
    output synth_pkg::stereo_sample_t out_sample
);

    localparam int DIV = `SYNTH_SAMPLE_DIV;
    localparam int CW  = $clog2(DIV);

    logic [CW-1:0] cnt;
    logic          terminal;

    assign terminal = (cnt == CW'(DIV - 1));

    // Held at terminal count until the output register is free
    assign sample_req = terminal && !out_valid;

    // ----------------------------------------
    // Rate divider and output handshake
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (!terminal) begin
                cnt <= cnt + 1'b1;
            end else if (sample_req) begin
                cnt <= '0;
            end

            if (sample_rdy) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;    // Accepted
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_rdy) begin
            out_sample <= sample;
        end
    end

endmodule

`default_nettype wire

/* source/synth_top.sv */
`timescale 1ns/100ps
`default_nettype none

module synth_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rx,
    input  logic                      out_ready,
    output logic                      out_valid,
    output synth_pkg::stereo_sample_t out_sample
);

    logic                      byte_valid;
    logic [7:0]                byte_data;

    logic                      msg_valid;
    synth_pkg::midi_msg_t      msg;

    logic                      sample_req;
    logic                      sample_rdy;
    synth_pkg::stereo_sample_t sample;

    // ----------------------------------------
    // Serial in to MIDI messages
    // ----------------------------------------
    uart_rx u_uart_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    midi_decoder u_midi_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .msg_valid  (msg_valid),
        .msg        (msg)
    );

    // ----------------------------------------
    // Voice and sample output
    // ----------------------------------------
    pulse_gen u_pulse_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .msg_valid  (msg_valid),
        .msg        (msg),
        .sample_req (sample_req),
        .sample_rdy (sample_rdy),
        .sample     (sample)
    );

    sample_out u_sample_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_ready  (out_ready),
        .sample_rdy (sample_rdy),
        .sample     (sample),
        .sample_req (sample_req),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

endmodule

`default_nettype wire

/* dv/synth_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module synth_assert #(
    parameter bit OUT_CHECKS = 1'b1,    // Output handshake checks
    parameter bit MSG_CHECKS = 1'b1     // Decoder pulse check
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      out_valid,
    input logic                      out_ready,
    input synth_pkg::stereo_sample_t out_sample,
    input logic                      msg_valid
);

    // Stalled output keeps both valid and data
    property stall_hold;
        @(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_sample);
    endproperty

    if (OUT_CHECKS) begin : g_out
        a_stall_hold: assert property (stall_hold)
            else $error("out_sample changed or out_valid dropped while the output was stalled");

        a_reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid)
            else $error("out_valid was high in the cycle after reset");
    end

    if (MSG_CHECKS) begin : g_msg
        a_msg_pulse: assert property (@(posedge clk) disable iff (!rst_n) msg_valid |=> !msg_valid)
            else $error("msg_valid stayed high for two cycles");
    end

endmodule

// ----------------------------------------
// Attach to the output stage and the decoder
// ----------------------------------------
bind sample_out synth_assert #(
    .OUT_CHECKS (1'b1),
    .MSG_CHECKS (1'b0)
) u_out_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_sample (out_sample),
    .msg_valid  (1'b0)
);

bind midi_decoder synth_assert #(
    .OUT_CHECKS (1'b0),
    .MSG_CHECKS (1'b1)
) u_msg_checks (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (1'b0),
    .out_ready  (1'b0),
    .out_sample (32'h0),
    .msg_valid  (msg_valid)
);

`default_nettype wire

/* dv/synth_tb.sv */
`include "synth_params.svh"
`timescale 1ns/100ps
`default_nettype none

module synth_tb;

    localparam int BIT_CLKS = `SYNTH_CLK_FREQ / `SYNTH_BAUD;
    localparam int TIMEOUT  = `SYNTH_TIMEOUT;

    logic                      clk;
    logic                      rst_n;
    logic                      rx;
    logic                      out_ready;
    logic                      out_valid;
    synth_pkg::stereo_sample_t out_sample;

    logic [15:0] note_lfsr;
    logic [15:0] stall_lfsr;
    logic        stall_en;      // Random out_ready when set
    int          errors;
    int          accepted;
    int          test_errors;
    int          test_accepted;

    // Model voice state
    logic               m_active;
    logic               m_phase;
    logic [6:0]         m_note;
    logic signed [15:0] m_amp;
    int                 m_cnt;
    int                 m_half;

    synth_pkg::midi_msg_t msg_q[$];   // Messages sent, not yet decoded
    logic signed [15:0]   exp_q[$];   // Requested samples, not yet accepted

    synth_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Random bits and reference model
    // ----------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;   // Galois taps 16 14 13 11
        end
        return n;
    endfunction

    function automatic int note_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | note_lfsr[0];
            note_lfsr = lfsr_next(note_lfsr);
        end
        return v;
    endfunction

    function automatic logic stall_bit();
        logic b;
        b = stall_lfsr[0];
        stall_lfsr = lfsr_next(stall_lfsr);
        return b;
    endfunction

    function automatic int half_period_ref(input logic [6:0] note);
        int semis[12];
        semis = '{3822, 3608, 3405, 3214, 3034, 2863, 2703, 2551, 2408, 2273, 2145, 2025};
        return semis[note % 12] >> (note / 12);
    endfunction

    // Level for one request, then the half-period step
    function automatic logic signed [15:0] next_sample();
        logic signed [15:0] v;
        v = 16'sd0;
        if (m_active) begin
            v = m_phase ? m_amp : -m_amp;
            if (m_cnt == m_half - 1) begin
                m_cnt   = 0;
                m_phase = ~m_phase;
            end else begin
                m_cnt = m_cnt + 1;
            end
        end
        return v;
    endfunction

    function automatic void apply_msg(input synth_pkg::midi_msg_t m);
        if (m.cmd == synth_pkg::CMD_NOTE_ON && m.data1 != 7'd0) begin
            m_active = 1'b1;
            m_phase  = 1'b1;
            m_cnt    = 0;
            m_note   = m.data0;
            m_half   = half_period_ref(m.data0);
            m_amp    = 16'(int'(m.data1) * 256);
        end else if ((m.cmd == synth_pkg::CMD_NOTE_OFF || m.cmd == synth_pkg::CMD_NOTE_ON) &&
                     m.data0 == m_note) begin
            m_active = 1'b0;
        end
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // Model steps on each request and each decoded message
    always @(posedge clk) begin : model_proc
        synth_pkg::midi_msg_t exp_msg;
        if (rst_n !== 1'b1) begin
            m_active = 1'b0;
            m_phase  = 1'b1;
            m_cnt    = 0;
            m_half   = 1;
            m_note   = '0;
            m_amp    = '0;
            exp_q.delete();
        end else begin
            if (DUT.u_sample_out.sample_req === 1'b1) begin
                exp_q.push_back(next_sample());
            end
            if (DUT.msg_valid === 1'b1) begin
                if (msg_q.size() == 0) begin
                    $display("ERROR at %0t: decoder emitted a message that was never sent", $time);
                    errors++;
                end else begin
                    exp_msg = msg_q.pop_front();
                    if (DUT.msg !== exp_msg) begin
                        $display("CHECK FAILED at %0t: msg got %h expected %h",
                                 $time, DUT.msg, exp_msg);
                        errors++;
                    end
                    apply_msg(exp_msg);
                end
            end
        end
    end

    always @(posedge clk) begin : compare_proc
        logic signed [15:0] exp_v;
        if (rst_n === 1'b1 && out_valid === 1'b1 && out_ready === 1'b1) begin
            accepted++;
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: a sample was accepted that was never requested", $time);
                errors++;
            end else begin
                exp_v = exp_q.pop_front();
                check_value("out_sample.left", $signed(out_sample.left), exp_v);
                check_value("out_sample.right", $signed(out_sample.right), exp_v);
            end
        end
    end

    always @(negedge clk) begin
        out_ready = (stall_en === 1'b1) ? stall_bit() : 1'b1;
    end

    // ----------------------------------------
    // UART driver and test helpers
    // ----------------------------------------
    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rx = 1'b0;                            // Start bit
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx = 1'b1;
        repeat (BIT_CLKS + 8) @(negedge clk); // Stop bit and a short gap
    endtask

    task automatic send_note(input logic [7:0] status, input logic [6:0] note,
                             input logic [6:0] vel, input logic running, input logic rt);
        synth_pkg::midi_msg_t m;
        m.cmd     = synth_pkg::midi_cmd_e'(status[7:4]);
        m.channel = status[3:0];
        m.data0   = note;
        m.data1   = vel;
        msg_q.push_back(m);
        if (!running) begin
            send_byte(status);
        end
        send_byte({1'b0, note});
        if (rt) begin
            send_byte(8'hF8);                 // Clock tick between data bytes
        end
        send_byte({1'b0, vel});
    endtask

    task automatic wait_samples(input int n);
        int target;
        int cycles;
        target = accepted + n;
        cycles = 0;
        while (accepted < target && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (accepted < target) begin
            $display("Timeout at %0t: the output stopped delivering samples", $time);
            $display("TEST FAILED");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        if (msg_q.size() != 0) begin
            $display("ERROR at %0t: %0d sent messages were never decoded", $time, msg_q.size());
            errors++;
            msg_q.delete();
        end
        $display("test %-14s %0d samples compared, %0d errors",
                 name, accepted - test_accepted, errors - test_errors);
        test_accepted = accepted;
        test_errors   = errors;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial begin
        int note;
        int vel;
        rx            = 1'b1;
        out_ready     = 1'b1;
        rst_n         = 1'b0;
        stall_en      = 1'b0;
        note_lfsr     = 16'd35;
        stall_lfsr    = 16'd35;
        errors        = 0;
        accepted      = 0;
        test_errors   = 0;
        test_accepted = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        wait_samples(20);
        end_test("silence");

        repeat (4) begin
            note = 84 + note_bits(6) % 36;
            vel  = note_bits(7);
            vel  = (vel == 0) ? 1 : vel;
            send_note({4'h9, 4'(note_bits(4))}, note, vel, 1'b0, 1'b0);
            wait_samples(4 * half_period_ref(note) + 8);
        end
        end_test("note_on");

        note = 84 + note_bits(6) % 36;
        send_note(8'h90, note, 100, 1'b0, 1'b0);
        wait_samples(20);
        send_note(8'h80, note + 1, 64, 1'b0, 1'b0);   // Other note, tone goes on
        wait_samples(20);
        send_note(8'h80, note, 64, 1'b1, 1'b0);
        wait_samples(10);
        send_note(8'h90, note, 90, 1'b0, 1'b0);
        wait_samples(20);
        send_note(8'h90, note, 0, 1'b1, 1'b0);        // Velocity 0 silences
        wait_samples(10);
        end_test("note_off");

        send_note(8'h92, 90, 80, 1'b0, 1'b0);
        wait_samples(30);
        send_note(8'h92, 97, 110, 1'b1, 1'b0);
        wait_samples(30);
        send_note(8'h92, 101, 50, 1'b1, 1'b1);
        wait_samples(30);
        send_note(8'h92, 101, 0, 1'b1, 1'b0);
        wait_samples(10);
        end_test("running_status");

        stall_en = 1'b1;
        repeat (3) begin
            note = 84 + note_bits(6) % 36;
            vel  = note_bits(7) | 1;
            send_note(8'h95, note, vel, 1'b0, 1'b0);
            wait_samples(40);
        end
        stall_en = 1'b0;
        wait_samples(5);
        end_test("back_pressure");

        $display("all tests: %0d samples compared, %0d errors", accepted, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/synth_pkg.sv
source/uart_rx.sv
source/midi_decoder.sv
source/pulse_gen.sv
source/sample_out.sv
source/synth_top.sv
dv/synth_assert.sv
dv/synth_tb.sv
